// File: testbench/l1Cases.txt
# op(1=write) bypass addr wdata be exp_rdata exp_err, all hex
# exp_rdata is only used for reads, writes are checked against the model
1 0 00000000 a0000000 f 0 0
1 0 00000004 a0000001 f 0 0
1 0 00000008 a0000002 f 0 0
1 0 0000000c a0000003 f 0 0
1 0 00000010 a0000004 f 0 0
1 0 00000400 b0000000 f 0 0
0 1 00000040 0 f a0000004 0
0 1 00000010 0 f b0000000 0
0 0 00000400 0 f b0000000 0
0 1 0000000c 0 f a0000003 0
0 0 00000010 0 f a0000004 0
1 0 00001000 c0000000 f 0 0
0 1 00001000 0 f c0000000 0
0 0 00001000 0 f c0000000 0
1 1 00001004 11223344 f 0 0
1 1 00001004 aabbccdd 5 0 0
1 0 00001004 99000000 8 0 0
0 1 00001004 0 f 99bb33dd 0
1 1 00004000 deadbeef f 0 1
0 1 00004000 0 f 0 1
0 0 fffffffc 0 f 0 1
0 1 00000000 0 f a0000000 0
0 0 00000000 0 f a0000000 0

// File: tb.f
verilog/l1Pkg.sv
verilog/bankSram.sv
verilog/memTile.sv
verilog/addressScrambler.sv
verilog/tileXbar.sv
verilog/l1Top.sv
testbench/tbL1_asserts.sv
testbench/tbL1.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the L1 scratchpad testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tbL1 -o simL1

out=$(./obj_dir/simL1)
echo "$out"

if grep -q "TB PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi

// File: testbench/tbL1.sv
// Testbench for the tiled L1 scratchpad. Replays the directed cases file, then
// issues random back-to-back traffic checked against a word-level memory model.
// Run from the project root so the cases file path resolves.

`timescale 1ns/1ps

module tbL1;

  localparam int unsigned NumRandom = 300;
  localparam int unsigned MaxCases  = 64;
  localparam int unsigned ResetCycles = 16;
  // Memory geometry of the default DUT
  localparam int unsigned MemWords = 4096;
  localparam logic [31:0] MemBytes = 32'h0000_4000;
  localparam logic [31:0] SeqEnd   = 32'h0000_1000;

  logic          clk_i;
  logic          rst_i;
  logic          bypass_i;
  logic          reqValid_i;
  l1Pkg::l1Req_t req_i;
  logic          respValid_o;
  l1Pkg::l1Resp_t resp_o;

  // Directed cases loaded from the file
  logic [31:0] caseOp [MaxCases];
  logic [31:0] caseByp [MaxCases];
  logic [31:0] caseAddr [MaxCases];
  logic [31:0] caseWdata [MaxCases];
  logic [31:0] caseBe [MaxCases];
  logic [31:0] caseRdata [MaxCases];
  logic [31:0] caseErr [MaxCases];
  int          numCases;

  // File expectation that travels with the current request
  logic        fromFile;
  logic [31:0] fileRdata;
  logic        fileErr;

  // Word model, indexed by physical word
  logic [31:0] model [MemWords];
  logic        known [MemWords];

  // Expected responses, two negedges deep for the two-cycle latency
  logic [1:0]  pipeV;
  logic [1:0]  pipeChk;
  logic [31:0] pipeRdata [2];
  logic [1:0]  pipeErr;

  logic [31:0] rngState;
  int          cycles;
  int          cycleLimit;
  int          errorCount;

  l1Top u_l1Top (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bypass_i   (bypass_i),
    .reqValid_i (reqValid_i),
    .req_i      (req_i),
    .respValid_o(respValid_o),
    .resp_o     (resp_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Sequential region swaps the tile id with the in-tile word bits
  function automatic logic [31:0] toPhys(input logic [31:0] a, input logic byp);
    if (!byp && a < SeqEnd) begin
      return {a[31:12], a[9:4], a[11:10], a[3:0]};
    end
    return a;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Response checks, then the expectation of the request now on the inputs
  always @(negedge clk_i) begin : respCheck
    logic [31:0] phys;
    logic [11:0] word;
    logic        err;
    logic [31:0] merged;
    check("respValid_o", {31'b0, respValid_o}, {31'b0, pipeV[1]});
    if (pipeV[1]) begin
      check("resp_o.err", {31'b0, resp_o.err}, {31'b0, pipeErr[1]});
      if (pipeChk[1]) begin
        check("resp_o.rdata", resp_o.rdata, pipeRdata[1]);
      end
    end
    pipeV[1] = pipeV[0];
    pipeChk[1] = pipeChk[0];
    pipeRdata[1] = pipeRdata[0];
    pipeErr[1] = pipeErr[0];
    phys = toPhys(req_i.addr, bypass_i);
    word = phys[13:2];
    err = phys >= MemBytes;
    pipeV[0] = reqValid_i;
    pipeErr[0] = err;
    pipeRdata[0] = err ? 32'h0 : model[word];
    pipeChk[0] = err || known[word];
    if (reqValid_i && fromFile) begin
      pipeErr[0] = fileErr;
      // Reads take their data from the file, writes from the model
      if (req_i.op == l1Pkg::OpRead) begin
        pipeRdata[0] = fileRdata;
        pipeChk[0] = 1'b1;
      end
    end
    if (reqValid_i && !err && req_i.op == l1Pkg::OpWrite) begin
      merged = model[word];
      for (int i = 0; i < 4; i++) begin
        if (req_i.be[i]) begin
          merged[i*8 +: 8] = req_i.wdata[i*8 +: 8];
        end
      end
      model[word] = merged;
      known[word] = known[word] || (req_i.be == 4'hf);
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic issue(input logic op, input logic byp, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic [3:0] be, input logic file,
                       input logic [31:0] expR, input logic expE);
    @(posedge clk_i);
    reqValid_i <= 1'b1;
    bypass_i <= byp;
    req_i.op <= l1Pkg::l1Op_e'(op);
    req_i.addr <= addr;
    req_i.wdata <= wdata;
    req_i.be <= be;
    fromFile <= file;
    fileRdata <= expR;
    fileErr <= expE;
  endtask

  task automatic loadCases();
    int    fd;
    int    n;
    string line;
    fd = $fopen("testbench/l1Cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file testbench/l1Cases.txt");
      $display("TB FAILED");
      $fatal(1, "missing cases file");
    end
    numCases = 0;
    while (!$feof(fd) && numCases < MaxCases) begin
      n = $fgets(line, fd);
      // Skip comment and blank lines
      if (n > 1 && line.getc(0) != 8'h23) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h", caseOp[numCases], caseByp[numCases],
                    caseAddr[numCases], caseWdata[numCases], caseBe[numCases],
                    caseRdata[numCases], caseErr[numCases]);
        if (n == 7) begin
          numCases++;
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin : main
    logic [31:0] r;
    logic [31:0] addr;
    clk_i = 1'b0;
    rst_i = 1'b1;
    bypass_i = 1'b0;
    reqValid_i = 1'b0;
    req_i = '0;
    fromFile = 1'b0;
    fileRdata = '0;
    fileErr = 1'b0;
    pipeV = '0;
    pipeChk = '0;
    pipeErr = '0;
    cycles = 0;
    cycleLimit = 1000;
    errorCount = 0;
    rngState = 32'he03e_280e;
    for (int i = 0; i < MemWords; i++) begin
      known[i] = 1'b0;
      model[i] = '0;
    end
    for (int i = 0; i < 2; i++) begin
      pipeRdata[i] = '0;
    end
    loadCases();
    cycleLimit = ResetCycles + numCases + NumRandom + 40;
    repeat (ResetCycles) @(posedge clk_i);
    rst_i <= 1'b0;
    // Idle a few cycles so respValid_o is seen low before the first request
    repeat (3) @(posedge clk_i);
    for (int i = 0; i < numCases; i++) begin
      issue(caseOp[i][0], caseByp[i][0], caseAddr[i], caseWdata[i], caseBe[i][3:0],
            1'b1, caseRdata[i], caseErr[i][0]);
    end
    for (int i = 0; i < NumRandom; i++) begin
      rngState = xorshift(rngState);
      r = rngState;
      // Mostly a narrow window for hits, sometimes out of range
      addr = (r[3:0] == 4'h0) ? (32'h0000_4000 | {r[31:16], 2'b00}) : (r & 32'h0000_1cfc);
      rngState = xorshift(rngState);
      issue(r[4], r[5], addr, rngState, r[9:6], 1'b0, 32'h0, 1'b0);
    end
    @(posedge clk_i);
    reqValid_i <= 1'b0;
    fromFile <= 1'b0;
    // Drain outstanding responses
    do begin
      @(posedge clk_i);
    end while (pipeV != 2'b00);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/tbL1_asserts.sv
// Assertions on the tile crossbar, bound into every tileXbar instance.
// Covers strobe decode, error gating, response timing and reset state.

`timescale 1ns/1ps

module tbL1_asserts #(
  parameter int unsigned NumTiles        = 4,
  parameter int unsigned NumBanksPerTile = 4,
  parameter int unsigned BankDepth       = 256
) (
  input logic                clk_i,
  input logic                rst_i,
  input logic                reqValid_i,
  input l1Pkg::l1Req_t       req_i,
  input logic [NumTiles-1:0] tileValid_i,
  input logic                respValid_i
);

  // Size of the whole memory in bytes
  localparam int unsigned MemBytes =
    NumTiles * NumBanksPerTile * BankDepth * l1Pkg::BytesPerWord;

  // Physical address past the last word
  logic beyond;

  assign beyond = req_i.addr >= MemBytes;

  // Geometry must be powers of two for the bit-field decode
  initial begin
    assert (NumTiles >= 1 && (NumTiles & (NumTiles - 1)) == 0)
      else $error("NumTiles is not a power of two");
    assert (NumBanksPerTile >= 1 && (NumBanksPerTile & (NumBanksPerTile - 1)) == 0)
      else $error("NumBanksPerTile is not a power of two");
    assert (BankDepth >= 2 && (BankDepth & (BankDepth - 1)) == 0)
      else $error("BankDepth is not a power of two");
  end

  // Exactly one tile per in-range request
  assert property (@(posedge clk_i) disable iff (rst_i)
    (reqValid_i && !beyond) |-> $onehot(tileValid_i))
    else $error("in-range request did not strobe exactly one tile");

  // Idle cycles and addresses past the memory reach no bank
  assert property (@(posedge clk_i) disable iff (rst_i)
    !(reqValid_i && !beyond) |-> tileValid_i == '0)
    else $error("tile strobed without an in-range request");

  // One stage here, the top-level output register adds the second
  assert property (@(posedge clk_i) disable iff (rst_i) respValid_i == $past(reqValid_i))
    else $error("response valid does not follow the request");

  // Pipeline empty right after reset
  assert property (@(posedge clk_i) rst_i |=> !respValid_i)
    else $error("response valid set after reset");

endmodule

bind tileXbar tbL1_asserts #(
  .NumTiles       (NumTiles),
  .NumBanksPerTile(NumBanksPerTile),
  .BankDepth      (BankDepth)
) u_asserts (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .reqValid_i  (reqValid_i),
  .req_i       (req_i),
  .tileValid_i (tileValid_o),
  .respValid_i (respValid_o)
);

// File: verilog/l1Top.sv
// Top level of the tiled L1 scratchpad for a single requester.
// A request on reqValid_i/req_i returns a one-cycle respValid_o pulse two
// cycles later. bypass_i switches the sequential-region remap off.

`timescale 1ns/1ps

module l1Top #(
  parameter int unsigned NumTiles          = 4,
  parameter int unsigned NumBanksPerTile   = 4,
  parameter int unsigned SeqMemSizePerTile = 1024,
  parameter int unsigned BankDepth         = 256
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            bypass_i,
  input  logic            reqValid_i,
  input  l1Pkg::l1Req_t   req_i,
  output logic            respValid_o,
  output l1Pkg::l1Resp_t  resp_o
);

  logic [l1Pkg::AddrWidth-1:0] scrAddr;
  l1Pkg::l1Req_t               physReq;

  // Crossbar to tiles
  logic [NumTiles-1:0]         tileValid;
  l1Pkg::l1Req_t               tileReq;
  logic [l1Pkg::DataWidth-1:0] tileRdata [NumTiles];

  // Unregistered crossbar response
  logic                        xbarRespValid;
  l1Pkg::l1Resp_t              xbarResp;

  // Output register
  logic                        respValidQ;
  l1Pkg::l1Resp_t              respQ;

  addressScrambler #(
    .NumTiles         (NumTiles),
    .NumBanksPerTile  (NumBanksPerTile),
    .SeqMemSizePerTile(SeqMemSizePerTile)
  ) u_scrambler (
    .bypass_i(bypass_i),
    .addr_i  (req_i.addr),
    .addr_o  (scrAddr)
  );

  // Same request with the physical address
  always_comb begin
    physReq      = req_i;
    physReq.addr = scrAddr;
  end

  tileXbar #(
    .NumTiles       (NumTiles),
    .NumBanksPerTile(NumBanksPerTile),
    .BankDepth      (BankDepth)
  ) u_xbar (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .reqValid_i (reqValid_i),
    .req_i      (physReq),
    .tileValid_o(tileValid),
    .tileReq_o  (tileReq),
    .tileRdata_i(tileRdata),
    .respValid_o(xbarRespValid),
    .resp_o     (xbarResp)
  );

  for (genvar t = 0; t < NumTiles; t++) begin : genTile
    memTile #(
      .NumTiles       (NumTiles),
      .NumBanksPerTile(NumBanksPerTile),
      .BankDepth      (BankDepth)
    ) u_tile (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .tileValid_i(tileValid[t]),
      .tileReq_i  (tileReq),
      .rdata_o    (tileRdata[t])
    );
  end

  // Second pipeline stage, valid only
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      respValidQ <= 1'b0;
    end else begin
      respValidQ <= xbarRespValid;
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    respQ <= xbarResp;
  end

  assign respValid_o = respValidQ;
  assign resp_o      = respQ;

endmodule

// File: verilog/tileXbar.sv
// Routes each physical request to the owning memory tile and picks the returning
// read data one cycle later. Out-of-range addresses get an error and reach no tile.

`timescale 1ns/1ps

module tileXbar #(
  parameter int unsigned NumTiles        = 4,
  parameter int unsigned NumBanksPerTile = 4,
  parameter int unsigned BankDepth       = 256
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         reqValid_i,
  input  l1Pkg::l1Req_t                req_i,
  output logic [NumTiles-1:0]          tileValid_o,
  output l1Pkg::l1Req_t                tileReq_o,
  input  logic [l1Pkg::DataWidth-1:0]  tileRdata_i [NumTiles],
  output logic                         respValid_o,
  output l1Pkg::l1Resp_t               resp_o
);

  // Physical layout from the LSB upward
  localparam int unsigned BankBits = $clog2(NumBanksPerTile);
  localparam int unsigned TileBits = $clog2(NumTiles);
  localparam int unsigned RowBits  = $clog2(BankDepth);
  localparam int unsigned TileLsb  = l1Pkg::ByteOffset + BankBits;
  // First address bit beyond the memory
  localparam int unsigned TopBit   = TileLsb + TileBits + RowBits;

  logic [TileBits-1:0] tileIdx;
  logic                outOfRange;

  // Pipeline state that travels with the bank access
  logic                respValidQ;
  logic                errQ;
  logic [TileBits-1:0] tileQ;

  assign tileIdx    = req_i.addr[TileLsb +: TileBits];
  assign outOfRange = |req_i.addr[l1Pkg::AddrWidth-1:TopBit];

  // All tiles see the same request, only the strobe differs
  assign tileReq_o = req_i;

  always_comb begin
    tileValid_o = '0;
    for (int t = 0; t < NumTiles; t++) begin
      // One strobe per in-range request
      tileValid_o[t] = reqValid_i && !outOfRange && (tileIdx == TileBits'(t));
    end
  end

  // Valid and error bits
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      respValidQ <= 1'b0;
      errQ       <= 1'b0;
    end else begin
      respValidQ <= reqValid_i;
      errQ       <= reqValid_i && outOfRange;
    end
  end

  // Tile select for the read-data mux
  always_ff @(posedge clk_i) begin
    if (reqValid_i) begin
      tileQ <= tileIdx;
    end
  end

  // Response mux
  always_comb begin
    resp_o.err   = errQ;
    resp_o.rdata = tileRdata_i[tileQ];
    // No bank was read on an error
    if (errQ) begin
      resp_o.rdata = '0;
    end
  end

  assign respValid_o = respValidQ;

endmodule

// File: verilog/addressScrambler.sv
// Remaps the lowest region of the address space so that each tile owns one
// contiguous block of words. Above that region the layout stays word interleaved.
// Purely combinational and sits in front of the tile crossbar.

`timescale 1ns/1ps

module addressScrambler #(
  parameter int unsigned NumTiles          = 4,
  parameter int unsigned NumBanksPerTile   = 4,
  parameter int unsigned SeqMemSizePerTile = 1024
) (
  input  logic                         bypass_i,
  input  logic [l1Pkg::AddrWidth-1:0]  addr_i,
  output logic [l1Pkg::AddrWidth-1:0]  addr_o
);

  // Field widths of the address
  localparam int unsigned BankBits      = $clog2(NumBanksPerTile);
  localparam int unsigned TileIdBits    = $clog2(NumTiles);
  localparam int unsigned SeqTileBits   = $clog2(SeqMemSizePerTile);
  localparam int unsigned SeqTotalBits  = SeqTileBits + TileIdBits;
  localparam int unsigned FixedLsbBits  = l1Pkg::ByteOffset + BankBits;
  localparam int unsigned InTileBits    = SeqTileBits - FixedLsbBits;

  // First byte address past the sequential region
  localparam logic [l1Pkg::AddrWidth-1:0] SeqRegionEnd =
    l1Pkg::AddrWidth'(NumTiles * SeqMemSizePerTile);

  // Word index inside one tile's sequential block
  logic [InTileBits-1:0] inTile;
  // Tile that owns the sequential block
  logic [TileIdBits-1:0] tileId;
  logic                  inSeqRegion;

  assign inTile      = addr_i[SeqTileBits-1:FixedLsbBits];
  assign tileId      = addr_i[SeqTotalBits-1:SeqTileBits];
  assign inSeqRegion = addr_i < SeqRegionEnd;

  // Byte and bank select bits never move
  assign addr_o[FixedLsbBits-1:0] = addr_i[FixedLsbBits-1:0];

  // Bits above the sequential region never move either
  assign addr_o[l1Pkg::AddrWidth-1:SeqTotalBits] = addr_i[l1Pkg::AddrWidth-1:SeqTotalBits];

  always_comb begin
    // Interleaved layout by default
    addr_o[SeqTotalBits-1:FixedLsbBits] = {tileId, inTile};
    // Inside the sequential region the tile id drops right above the bank bits
    if (!bypass_i && inSeqRegion) begin
      addr_o[SeqTotalBits-1:FixedLsbBits] = {inTile, tileId};
    end
  end

endmodule

// File: verilog/memTile.sv
// One memory tile: a set of single-port banks behind a bank decoder.
// Takes the shared physical request plus its own strobe and returns the read
// word of the bank it accessed on the previous edge.

`timescale 1ns/1ps

module memTile #(
  parameter int unsigned NumTiles        = 4,
  parameter int unsigned NumBanksPerTile = 4,
  parameter int unsigned BankDepth       = 256
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         tileValid_i,
  input  l1Pkg::l1Req_t                tileReq_i,
  output logic [l1Pkg::DataWidth-1:0]  rdata_o
);

  // Field positions inside the physical address
  localparam int unsigned BankBits = $clog2(NumBanksPerTile);
  localparam int unsigned TileBits = $clog2(NumTiles);
  localparam int unsigned RowBits  = $clog2(BankDepth);
  localparam int unsigned BankLsb  = l1Pkg::ByteOffset;
  // Rows start above the tile index
  localparam int unsigned RowLsb   = BankLsb + BankBits + TileBits;

  logic [BankBits-1:0]         bankIdx;
  logic [RowBits-1:0]          row;
  logic                        we;
  logic [NumBanksPerTile-1:0]  bankEn;
  logic [l1Pkg::DataWidth-1:0] bankRdata [NumBanksPerTile];

  // Bank that holds last cycle's word
  logic [BankBits-1:0]         bankQ;

  assign bankIdx = tileReq_i.addr[BankLsb +: BankBits];
  assign row     = tileReq_i.addr[RowLsb +: RowBits];
  assign we      = tileReq_i.op == l1Pkg::OpWrite;

  always_comb begin
    bankEn = '0;
    for (int b = 0; b < NumBanksPerTile; b++) begin
      bankEn[b] = tileValid_i && (bankIdx == BankBits'(b));
    end
  end

  for (genvar b = 0; b < NumBanksPerTile; b++) begin : genBank
    // Banks share row, data and byte enables
    bankSram #(
      .Depth(BankDepth)
    ) u_bank (
      .clk_i  (clk_i),
      .en_i   (bankEn[b]),
      .we_i   (we),
      .be_i   (tileReq_i.be),
      .row_i  (row),
      .wdata_i(tileReq_i.wdata),
      .rdata_o(bankRdata[b])
    );
  end

  // Track which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bankQ <= '0;
    end else if (tileValid_i) begin
      bankQ <= bankIdx;
    end
  end

  // Read-data mux
  assign rdata_o = bankRdata[bankQ];

endmodule

// File: verilog/bankSram.sv
// Word-wide single-port memory bank with per-byte write enables.
// Read data is registered on the access edge and shows the old word on a write.

`timescale 1ns/1ps

module bankSram #(
  parameter int unsigned Depth = 256
) (
  input  logic                            clk_i,
  input  logic                            en_i,
  input  logic                            we_i,
  input  logic [l1Pkg::BytesPerWord-1:0]  be_i,
  input  logic [$clog2(Depth)-1:0]        row_i,
  input  logic [l1Pkg::DataWidth-1:0]     wdata_i,
  output logic [l1Pkg::DataWidth-1:0]     rdata_o
);

  logic [l1Pkg::DataWidth-1:0] mem [Depth];
  logic [l1Pkg::DataWidth-1:0] rdataQ;

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      // Old word goes out, also on a write
      rdataQ <= mem[row_i];
      if (we_i) begin
        for (int i = 0; i < l1Pkg::BytesPerWord; i++) begin
          // Only the enabled bytes change
          if (be_i[i]) begin
            mem[row_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end
    end
  end

  assign rdata_o = rdataQ;

endmodule

// File: verilog/l1Pkg.sv
// Shared widths, request opcodes and the request and response structs for the
// tiled L1 scratchpad. Every RTL file and the testbench refer to these by scoped names.

package l1Pkg;

  // Fixed bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Bytes per word and the address bits that select a byte
  localparam int unsigned BytesPerWord = DataWidth / 8;
  localparam int unsigned ByteOffset = $clog2(BytesPerWord);

  // Request operation
  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } l1Op_e;

  // One request from the requester, 69 bits
  typedef struct packed {
    l1Op_e                 op;
    logic [AddrWidth-1:0]  addr;
    logic [DataWidth-1:0]  wdata;
    logic [BytesPerWord-1:0] be;
  } l1Req_t;

  // One response back to the requester, 33 bits
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } l1Resp_t;

endpackage
